// File: hdl/cache_pkg.sv
package cache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Address split and cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTE_W   = 8;               // One DRAM beat

    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;

    localparam int SETS       = 128;           // 2**INDEX_W lines
    localparam int LINE_BYTES = 32;            // Also beats per burst

    ////////////////////////////////////////////////////////////////////////////
    // DRAM model
    ////////////////////////////////////////////////////////////////////////////

    localparam int DRAM_ADDR_W  = 14;          // 16 KiB, upper bits ignored
    localparam int DRAM_LATENCY = 4;

    // Latency plus burst counter inside the DRAM model
    localparam int DRAM_CNT_W = $clog2(DRAM_LATENCY + LINE_BYTES);
    localparam logic [DRAM_CNT_W-1:0] DRAM_FIRST_BEAT = DRAM_CNT_W'(DRAM_LATENCY);
    localparam logic [DRAM_CNT_W-1:0] DRAM_LAST_BEAT =
        DRAM_CNT_W'(DRAM_LATENCY + LINE_BYTES - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_lw,
        op_lb,
        op_lbu,
        op_sw,
        op_sb
    } mem_op_e;

    typedef enum logic [1:0] {
        cmd_idle,
        cmd_read,
        cmd_write
    } mem_cmd_e;

    typedef enum logic [1:0] {
        st_lookup,
        st_evict,
        st_fill
    } ctrl_state_e;

endpackage

// File: hdl/burst_counter.sv
module burst_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          beat_start,
    input  logic                          mem_ready,
    output logic [cache_pkg::OFFSET_W-1:0] beat,
    output logic                          last_beat
);

    ////////////////////////////////////////////////////////////////////////////
    // Beat position within the current line transfer
    ////////////////////////////////////////////////////////////////////////////

    // One step per ready beat. The count wraps to zero after beat 31, so
    // an eviction hands over to the refill already at beat 0.
    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (beat_start) begin
            beat <= '0;                     // New miss
        end else if (mem_ready) begin
            beat <= beat + 1'b1;
        end
    end

    // Final byte of the line is on the bus
    assign last_beat = mem_ready && (&beat);

endmodule

// File: hdl/tag_store.sv
module tag_store (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cache_pkg::INDEX_W-1:0] index,
    input  logic [cache_pkg::TAG_W-1:0]   tag,
    input  logic                         tag_update,
    output logic                         hit,
    output logic                         victim_valid,
    output logic [cache_pkg::TAG_W-1:0]   victim_tag
);

    logic [cache_pkg::SETS-1:0]  valid;
    logic [cache_pkg::TAG_W-1:0] tags [cache_pkg::SETS];

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    assign victim_valid = valid[index];
    assign victim_tag   = tags[index];      // Stays put until the fill completes
    assign hit          = victim_valid && (victim_tag == tag);

    ////////////////////////////////////////////////////////////////////////////
    // Update at the end of a refill
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (tag_update) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_update) begin
            tags[index] <= tag;
        end
    end

endmodule

// File: hdl/line_store.sv
module line_store (
    input  logic                          clk,
    input  logic [cache_pkg::INDEX_W-1:0]  index,
    input  logic [cache_pkg::OFFSET_W-1:0] offset,
    input  logic [cache_pkg::OFFSET_W-1:0] beat,
    input  cache_pkg::mem_op_e            cpu_op,
    input  logic [cache_pkg::DATA_W-1:0]   cpu_wdata,
    input  logic                          load_accept,
    input  logic                          store_accept,
    input  logic                          fill_we,
    input  logic [cache_pkg::BYTE_W-1:0]   fill_data,
    output logic [cache_pkg::BYTE_W-1:0]   evict_data,
    output logic                          cpu_rvalid,
    output logic [cache_pkg::DATA_W-1:0]   cpu_rdata
);

    localparam int LOC_W = cache_pkg::INDEX_W + cache_pkg::OFFSET_W;

    logic [cache_pkg::BYTE_W-1:0] data [cache_pkg::SETS * cache_pkg::LINE_BYTES];

    logic [LOC_W-1:0]             beat_loc;
    logic [LOC_W-1:0]             byte_loc;
    logic [LOC_W-3:0]             word_loc;  // Aligned word, bits [1:0] dropped
    logic [cache_pkg::BYTE_W-1:0] rd_byte;
    logic [cache_pkg::DATA_W-1:0] rd_word;

    assign beat_loc = {index, beat};
    assign byte_loc = {index, offset};
    assign word_loc = byte_loc[LOC_W-1:2];

    // Little endian, byte 0 at the lowest address
    assign rd_byte = data[byte_loc];
    assign rd_word = {data[{word_loc, 2'd3}], data[{word_loc, 2'd2}],
                      data[{word_loc, 2'd1}], data[{word_loc, 2'd0}]};

    assign evict_data = data[beat_loc];

    ////////////////////////////////////////////////////////////////////////////
    // Array writes
    ////////////////////////////////////////////////////////////////////////////

    // Fill and CPU store never share a cycle
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data[beat_loc] <= fill_data;
        end
        if (store_accept) begin
            if (cpu_op == cache_pkg::op_sw) begin
                for (int i = 0; i < 4; i++) begin
                    data[{word_loc, 2'(i)}] <= cpu_wdata[i*cache_pkg::BYTE_W +: cache_pkg::BYTE_W];
                end
            end else begin
                data[byte_loc] <= cpu_wdata[cache_pkg::BYTE_W-1:0];    // SB
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load result, one cycle after acceptance
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        cpu_rvalid <= load_accept;
    end

    always_ff @(posedge clk) begin
        if (load_accept) begin
            case (cpu_op)
                cache_pkg::op_lw: cpu_rdata <= rd_word;
                cache_pkg::op_lb: cpu_rdata <= {{(cache_pkg::DATA_W - cache_pkg::BYTE_W)
                                                {rd_byte[cache_pkg::BYTE_W-1]}}, rd_byte};
                default:          cpu_rdata <= {{(cache_pkg::DATA_W - cache_pkg::BYTE_W)
                                                {1'b0}}, rd_byte};       // LBU
            endcase
        end
    end

endmodule

// File: hdl/cache_ctrl.sv
module cache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_valid,
    input  cache_pkg::mem_op_e  cpu_op,
    input  logic                hit,
    input  logic                victim_valid,
    input  logic                mem_ready,
    input  logic                last_beat,
    output logic                cpu_stall,
    output logic                load_accept,
    output logic                store_accept,
    output cache_pkg::mem_cmd_e mem_cmd,
    output logic                beat_start,
    output logic                fill_we,
    output logic                tag_update,
    output logic                use_victim_tag
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e state_next;

    logic in_lookup;
    logic miss;
    logic is_load;
    logic burst_done;

    assign in_lookup  = (state == cache_pkg::st_lookup);
    assign miss       = in_lookup && cpu_valid && !hit;
    assign burst_done = mem_ready && last_beat;

    assign is_load = (cpu_op == cache_pkg::op_lw) ||
                     (cpu_op == cache_pkg::op_lb) ||
                     (cpu_op == cache_pkg::op_lbu);

    ////////////////////////////////////////////////////////////////////////////
    // Miss state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::st_lookup: begin
                if (miss) begin
                    // Valid victim goes back to DRAM before the refill
                    state_next = victim_valid ? cache_pkg::st_evict : cache_pkg::st_fill;
                end
            end
            cache_pkg::st_evict: begin
                if (burst_done) begin
                    state_next = cache_pkg::st_fill;
                end
            end
            cache_pkg::st_fill: begin
                if (burst_done) begin
                    state_next = cache_pkg::st_lookup;  // Held request retries as a hit
                end
            end
            default: state_next = cache_pkg::st_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::st_lookup;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    // Stall covers the miss cycle itself and every burst cycle
    assign cpu_stall = !in_lookup || miss;

    assign load_accept  = in_lookup && cpu_valid && hit && is_load;
    assign store_accept = in_lookup && cpu_valid && hit && !is_load;

    always_comb begin
        case (state)
            cache_pkg::st_evict: mem_cmd = cache_pkg::cmd_write;
            cache_pkg::st_fill:  mem_cmd = cache_pkg::cmd_read;
            default:             mem_cmd = cache_pkg::cmd_idle;
        endcase
    end

    assign beat_start     = miss;                      // Counter at beat 0 for the first burst
    assign fill_we        = (state == cache_pkg::st_fill) && mem_ready;
    assign tag_update     = (state == cache_pkg::st_fill) && burst_done;
    assign use_victim_tag = (state == cache_pkg::st_evict);

endmodule

// File: hdl/dram_model.sv
module dram_model (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_pkg::mem_cmd_e         mem_cmd,
    input  logic [cache_pkg::ADDR_W-1:0] mem_addr,
    input  logic [cache_pkg::BYTE_W-1:0] mem_wdata,
    output logic                        mem_ready,
    output logic [cache_pkg::BYTE_W-1:0] mem_rdata
);

    logic [cache_pkg::BYTE_W-1:0]      mem [2**cache_pkg::DRAM_ADDR_W];
    logic [cache_pkg::DRAM_ADDR_W-1:0] addr;
    logic [cache_pkg::DRAM_CNT_W-1:0]  cnt;     // Latency cycles, then beats
    logic                              busy;

    // DRAM contents start out as all zero
    initial begin
        for (int i = 0; i < 2**cache_pkg::DRAM_ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    assign addr = mem_addr[cache_pkg::DRAM_ADDR_W-1:0];
    assign busy = (mem_cmd != cache_pkg::cmd_idle);

    ////////////////////////////////////////////////////////////////////////////
    // Burst timing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (!busy) begin
            cnt <= '0;
        end else if (cnt == cache_pkg::DRAM_LAST_BEAT) begin
            cnt <= '0;          // Next command waits the full latency again
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // 32 consecutive ready cycles once the latency has run out
    assign mem_ready = busy && (cnt >= cache_pkg::DRAM_FIRST_BEAT);

    ////////////////////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////////////////////

    assign mem_rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (mem_ready && (mem_cmd == cache_pkg::cmd_write)) begin
            mem[addr] <= mem_wdata;
        end
    end

endmodule

// File: hdl/cache_top.sv
module cache_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_valid,
    input  cache_pkg::mem_op_e          cpu_op,
    input  logic [cache_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [cache_pkg::DATA_W-1:0] cpu_wdata,
    output logic                        cpu_stall,
    output logic                        cpu_rvalid,
    output logic [cache_pkg::DATA_W-1:0] cpu_rdata
);

    // Address fields
    logic [cache_pkg::TAG_W-1:0]    tag;
    logic [cache_pkg::INDEX_W-1:0]  index;
    logic [cache_pkg::OFFSET_W-1:0] offset;

    // Controller and lookup
    logic                         hit;
    logic                         victim_valid;
    logic [cache_pkg::TAG_W-1:0]  victim_tag;
    logic                         load_accept;
    logic                         store_accept;
    logic                         beat_start;
    logic                         fill_we;
    logic                         tag_update;
    logic                         use_victim_tag;

    // DRAM link
    cache_pkg::mem_cmd_e            mem_cmd;
    logic [cache_pkg::ADDR_W-1:0]   mem_addr;
    logic [cache_pkg::BYTE_W-1:0]   mem_wdata;
    logic [cache_pkg::BYTE_W-1:0]   mem_rdata;
    logic                           mem_ready;
    logic [cache_pkg::OFFSET_W-1:0] beat;
    logic                           last_beat;

    assign tag    = cpu_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
    assign index  = cpu_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign offset = cpu_addr[cache_pkg::OFFSET_W-1:0];

    // Eviction writes to the old owner of the line, refill reads the new one
    assign mem_addr = {(use_victim_tag ? victim_tag : tag), index, beat};

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_valid      (cpu_valid),
        .cpu_op         (cpu_op),
        .hit            (hit),
        .victim_valid   (victim_valid),
        .mem_ready      (mem_ready),
        .last_beat      (last_beat),
        .cpu_stall      (cpu_stall),
        .load_accept    (load_accept),
        .store_accept   (store_accept),
        .mem_cmd        (mem_cmd),
        .beat_start     (beat_start),
        .fill_we        (fill_we),
        .tag_update     (tag_update),
        .use_victim_tag (use_victim_tag)
    );

    burst_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .beat_start (beat_start),
        .mem_ready  (mem_ready),
        .beat       (beat),
        .last_beat  (last_beat)
    );

    tag_store u_tags (
        .clk          (clk),
        .rst          (rst),
        .index        (index),
        .tag          (tag),
        .tag_update   (tag_update),
        .hit          (hit),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag)
    );

    line_store u_lines (
        .clk          (clk),
        .index        (index),
        .offset       (offset),
        .beat         (beat),
        .cpu_op       (cpu_op),
        .cpu_wdata    (cpu_wdata),
        .load_accept  (load_accept),
        .store_accept (store_accept),
        .fill_we      (fill_we),
        .fill_data    (mem_rdata),
        .evict_data   (mem_wdata),
        .cpu_rvalid   (cpu_rvalid),
        .cpu_rdata    (cpu_rdata)
    );

    dram_model u_dram (
        .clk       (clk),
        .rst       (rst),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: verification/cache_sva.sv
module cache_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   cpu_valid,
    input cache_pkg::mem_op_e     cpu_op,
    input logic                   cpu_stall,
    input logic                   cpu_rvalid,
    input cache_pkg::mem_cmd_e    mem_cmd,
    input logic                   mem_ready,
    input logic                   last_beat,
    input cache_pkg::ctrl_state_e state
);
    timeunit 1ns;
    timeprecision 1ps;

    logic load_fire;

    // Load taken by the cache on this edge
    assign load_fire = cpu_valid && !cpu_stall &&
                       ((cpu_op == cache_pkg::op_lw) ||
                        (cpu_op == cache_pkg::op_lb) ||
                        (cpu_op == cache_pkg::op_lbu));

    rvalid_after_load: assert property (@(posedge clk) disable iff (rst)
        cpu_rvalid |-> $past(load_fire))
        else $error("cpu_rvalid high without a load accepted in the previous cycle");

    cmd_stable_in_burst: assert property (@(posedge clk) disable iff (rst)
        (mem_ready && !last_beat) |=> $stable(mem_cmd))
        else $error("mem_cmd changed in the middle of a burst");

    // A burst may only start from a cycle that held the requester
    lookup_when_free: assert property (@(posedge clk) disable iff (rst)
        !cpu_stall |=> (state == cache_pkg::st_lookup))
        else $error("Controller left st_lookup after a cycle without a stall");

endmodule

bind cache_top cache_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .cpu_valid  (cpu_valid),
    .cpu_op     (cpu_op),
    .cpu_stall  (cpu_stall),
    .cpu_rvalid (cpu_rvalid),
    .mem_cmd    (mem_cmd),
    .mem_ready  (mem_ready),
    .last_beat  (last_beat),
    .state      (u_ctrl.state)
);

// File: verification/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 5;
    localparam int    TEXT_W       = 8 * 16;   // Up to 16 characters per name
    localparam string INPUT_FILE   = "verification/cache_input.txt";

    logic                 clk;
    logic                 rst;
    logic                 cpu_valid;
    cache_pkg::mem_op_e   cpu_op;
    logic [31:0]          cpu_addr;
    logic [31:0]          cpu_wdata;
    logic                 cpu_stall;
    logic                 cpu_rvalid;
    logic [31:0]          cpu_rdata;

    // One entry per vector line
    logic [TEXT_W-1:0]    name_q  [$];
    cache_pkg::mem_op_e   op_q    [$];
    logic [31:0]          addr_q  [$];
    logic [31:0]          wdata_q [$];
    logic [31:0]          rdata_q [$];
    logic                 stall_q [$];

    int   num_vectors;
    int   error_count;
    int   pass_tests;
    int   fail_tests;
    logic load_ok;

    cache_top uut (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .cpu_op     (cpu_op),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_stall  (cpu_stall),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check(input logic [TEXT_W-1:0] test_name, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %0s %0s: expected %08h, actual %08h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    function automatic logic decode_op(input logic [TEXT_W-1:0] op_text,
                                       output cache_pkg::mem_op_e op);
        decode_op = 1'b1;
        op = cache_pkg::op_lw;
        if (op_text == TEXT_W'("lw")) op = cache_pkg::op_lw;
        else if (op_text == TEXT_W'("lb")) op = cache_pkg::op_lb;
        else if (op_text == TEXT_W'("lbu")) op = cache_pkg::op_lbu;
        else if (op_text == TEXT_W'("sw")) op = cache_pkg::op_sw;
        else if (op_text == TEXT_W'("sb")) op = cache_pkg::op_sb;
        else decode_op = 1'b0;
    endfunction

    function automatic logic is_load_op(input cache_pkg::mem_op_e op);
        return (op == cache_pkg::op_lw) || (op == cache_pkg::op_lb) ||
               (op == cache_pkg::op_lbu);
    endfunction

    task automatic read_vectors();
        int                 fd;
        int                 n;
        int                 line_no;
        string              line;
        logic [TEXT_W-1:0]  name_text;
        logic [TEXT_W-1:0]  op_text;
        logic [31:0]        addr;
        logic [31:0]        wdata;
        logic [31:0]        rdata;
        logic [31:0]        stall;
        cache_pkg::mem_op_e op;
        load_ok = 1'b1;
        line_no = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %0s", INPUT_FILE);
            load_ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                line_no++;
                if (n > 0 && line.getc(0) != "#") begin   // Skip column notes
                    n = $sscanf(line, "%s %s %h %h %h %d",
                                name_text, op_text, addr, wdata, rdata, stall);
                    if (n == 6 && decode_op(op_text, op)) begin
                        name_q.push_back(name_text);
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        wdata_q.push_back(wdata);
                        rdata_q.push_back(rdata);
                        stall_q.push_back(stall[0]);
                    end else if (n > 0) begin
                        $display("Line %0d of the vector file cannot be parsed", line_no);
                        load_ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (name_q.size() == 0) begin
                $display("The vector file holds no requests");
                load_ok = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One request, held through any stall
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_test(input int k);
        int   errors_before;
        logic stalled;
        errors_before = error_count;
        stalled = 1'b0;
        @(posedge clk);
        #1;
        cpu_valid = 1'b1;
        cpu_op    = op_q[k];
        cpu_addr  = addr_q[k];
        cpu_wdata = wdata_q[k];
        @(negedge clk);
        while (cpu_stall) begin
            stalled = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);                          // Acceptance edge
        #1;
        cpu_valid = 1'b0;
        @(negedge clk);
        check(name_q[k], "cpu_stall", {31'd0, stall_q[k]}, {31'd0, stalled});
        if (is_load_op(op_q[k])) begin
            if (cpu_rvalid !== 1'b1) begin
                $display("%0s: cpu_rvalid did not rise in the cycle after the load",
                         name_q[k]);
                error_count++;
            end else begin
                check(name_q[k], "cpu_rdata", rdata_q[k], cpu_rdata);
            end
        end else begin
            check(name_q[k], "cpu_rvalid", 32'd0, {31'd0, cpu_rvalid});
        end
        if (error_count == errors_before) begin
            pass_tests++;
            $display("ok    %0s", name_q[k]);
        end else begin
            fail_tests++;
            $display("bad   %0s", name_q[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cpu_valid   = 1'b0;
        cpu_op      = cache_pkg::op_lw;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        error_count = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        num_vectors = 0;
        read_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check(TEXT_W'("reset"), "cpu_stall", 32'd0, {31'd0, cpu_stall});
        check(TEXT_W'("reset"), "cpu_rvalid", 32'd0, {31'd0, cpu_rvalid});
        if (!load_ok) begin
            $display("No tests were run since the vectors could not be loaded");
            $display("TEST RESULT: FAIL");
        end else begin
            num_vectors = name_q.size();
            for (int k = 0; k < num_vectors; k++) begin
                run_test(k);
            end
            $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
                     num_vectors, pass_tests, fail_tests, error_count);
            if (error_count == 0 && fail_tests == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

    // Worst case per request is an eviction plus a refill
    initial begin : watchdog
        int limit_cycles;
        wait (num_vectors > 0);
        limit_cycles = num_vectors * 2 * (cache_pkg::DRAM_LATENCY + 34) + RESET_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with requests still pending",
                 limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: filelist.f
hdl/cache_pkg.sv
hdl/burst_counter.sv
hdl/tag_store.sv
hdl/line_store.sv
hdl/cache_ctrl.sv
hdl/dram_model.sv
hdl/cache_top.sv
verification/cache_sva.sv
verification/cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -Mdir obj_dir -o cache_sim \
    -f filelist.f > "$LOG" 2>&1 \
    && ./obj_dir/cache_sim >> "$LOG" 2>&1 \
    || echo "Build or simulation exited with an error" >> "$LOG"

cat "$LOG"

grep -q "TEST RESULT: FAIL" "$LOG" && exit 1
grep -q "TEST RESULT: PASS" "$LOG" || exit 1
exit 0

// File: verification/cache_input.txt
# name          op    addr      wdata     exp_rdata stall
# exp_rdata unused for stores, stall is 1 when the request waits on a miss
cold_lw         lw    00000100  00000000  00000000  1
sw_word         sw    00000104  12345678  00000000  0
lw_word         lw    00000104  00000000  12345678  0
sb_neg          sb    00000105  00000080  00000000  0
lb_neg          lb    00000105  00000000  ffffff80  0
lbu_pos         lbu   00000105  00000000  00000080  0
lw_neighbors    lw    00000104  00000000  12348078  0
sw_a            sw    00000200  cafef00d  00000000  1
lw_alias        lw    00001200  00000000  00000000  1
lw_a_back       lw    00000200  00000000  cafef00d  1
sb_alias        sb    00001104  000000ab  00000000  1
sw_alloc        sw    00000108  0badbeef  00000000  1
lw_prior        lw    00000104  00000000  12348078  0
lw_stored       lw    00000108  00000000  0badbeef  0
lbu_back        lbu   00001104  00000000  000000ab  1
lb_next         lb    00001105  00000000  00000000  0
